// ==== hw/icache_settings.svh ====
// **********************************************************************
// Cache geometry and address width macros
// **********************************************************************
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Byte address, 16 sets of four-word lines
`define ICACHE_ADDR_W     32
`define ICACHE_SETS       16
`define ICACHE_LINE_WORDS 4
// Address less index, word offset and byte bits
`define ICACHE_TAG_W      24

`endif

// ==== hw/icachePkg.sv ====
// **********************************************************************
// Types for fetch requests, bus address phases and array entries
// **********************************************************************
`default_nettype none
`include "icache_settings.svh"

package icachePkg;

  // Fetch request from the processor
  typedef struct packed {
    logic [`ICACHE_ADDR_W-1:0] addr;
  } fetchReqT;

  // One tag array entry
  typedef struct packed {
    logic                     valid;
    logic [`ICACHE_TAG_W-1:0] tag;
  } tagEntryT;

  // Address phase, word aligned
  typedef struct packed {
    logic                      valid;
    logic [`ICACHE_ADDR_W-1:0] addr;
  } busReqT;

  // Instruction word, shared by data arrays and bus
  typedef logic [31:0] wordT;

endpackage

`default_nettype wire

// ==== hw/icacheWayArray.sv ====
// **********************************************************************
// Storage for one cache way, generic in its entry type
// **********************************************************************
`timescale 1ns/1ps
`default_nettype none

module icacheWayArray #(
  parameter type entryT = logic [31:0],
  parameter int  depth  = 16
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     writeEnable,
  input  logic [$clog2(depth)-1:0] writeIndex,
  input  entryT                    writeEntry,
  input  logic [$clog2(depth)-1:0] readIndex,
  output entryT                    readEntry
);

  entryT entries [depth];

  // One entry per cycle, cleared on reset so tags start invalid
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        entries[i] <= '0;
      end
    end else if (writeEnable) begin
      entries[writeIndex] <= writeEntry;
    end
  end

  // Combinational read
  assign readEntry = entries[readIndex];

endmodule

`default_nettype wire

// ==== hw/icacheController.sv ====
// **********************************************************************
// Hit detection, refill FSM, beat counters, LRU bits and way writes
// **********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "icache_settings.svh"

module icacheController
  import icachePkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     cacheEnable,
  input  logic     fetchValid,
  input  fetchReqT fetchReq,
  output logic     fetchReady,
  output wordT     fetchInstr,
  input  tagEntryT tagRead0,
  input  tagEntryT tagRead1,
  input  wordT     dataRead0,
  input  wordT     dataRead1,
  output logic     tagWrite0,
  output logic     tagWrite1,
  output tagEntryT tagWriteEntry,
  output logic     dataWrite0,
  output logic     dataWrite1,
  output logic [$clog2(`ICACHE_SETS)+$clog2(`ICACHE_LINE_WORDS)-1:0] dataWriteIndex,
  output busReqT   busReq,
  input  logic     busReady,
  input  wordT     busRdata
);

  localparam int indexW  = $clog2(`ICACHE_SETS);
  localparam int offsetW = $clog2(`ICACHE_LINE_WORDS);

  typedef enum logic [1:0] {idle, fill, lastBeat, settle} stateT;

  stateT                    state;
  stateT                    nextState;
  logic [`ICACHE_TAG_W-1:0] reqTag;
  logic [indexW-1:0]        reqIndex;
  logic                     hit0;
  logic                     hit1;
  logic                     hit;
  logic [`ICACHE_SETS-1:0]  lruBits;
  logic                     victim;
  logic                     victimNext;
  logic                     bypass;
  logic [offsetW-1:0]       addrCount;
  logic [offsetW-1:0]       dataCount;
  logic                     dataBeat;
  logic                     lastData;
  wordT                     uncachedWord;

  // Address fields
  assign reqTag   = fetchReq.addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign reqIndex = fetchReq.addr[offsetW+2 +: indexW];

  // Tag compare on both ways
  assign hit0 = tagRead0.valid && (tagRead0.tag == reqTag);
  assign hit1 = tagRead1.valid && (tagRead1.tag == reqTag);
  assign hit  = cacheEnable && (hit0 || hit1);

  // Empty ways first, way 0 before way 1, then the LRU choice
  always_comb begin
    if (!tagRead0.valid) begin
      victimNext = 1'b0;
    end else if (!tagRead1.valid) begin
      victimNext = 1'b1;
    end else begin
      victimNext = lruBits[reqIndex];
    end
  end

  // Hits answer in idle, uncached words in settle
  assign fetchReady = ((state == idle) && hit) || ((state == settle) && bypass);
  assign fetchInstr = (state == settle) ? uncachedWord : (hit1 ? dataRead1 : dataRead0);

  always_comb begin
    nextState = state;
    case (state)
      idle:     if (fetchValid && !hit) nextState = fill;
      // An uncached read needs only one address phase
      fill:     if (busReady && (bypass || addrCount == '1)) nextState = lastBeat;
      lastBeat: if (busReady) nextState = settle;
      settle:   nextState = idle;
      default:  nextState = idle;
    endcase
  end

  // Data phase trails the address phase by one accepted beat
  assign dataBeat = !bypass && busReady &&
                    (((state == fill) && (addrCount != '0)) || (state == lastBeat));
  assign lastData = !bypass && busReady && (state == lastBeat);

  assign dataWrite0     = dataBeat && !victim;
  assign dataWrite1     = dataBeat && victim;
  assign dataWriteIndex = {reqIndex, dataCount};

  // Tag goes in with the last word so a partial line never hits
  assign tagWrite0     = lastData && !victim;
  assign tagWrite1     = lastData && victim;
  assign tagWriteEntry = '{valid: 1'b1, tag: reqTag};

  always_comb begin
    busReq.valid = (state == fill);
    if (bypass) begin
      busReq.addr = {fetchReq.addr[`ICACHE_ADDR_W-1:2], 2'b00};
    end else begin
      busReq.addr = {reqTag, reqIndex, addrCount, 2'b00};
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state     <= idle;
      victim    <= 1'b0;
      bypass    <= 1'b0;
      addrCount <= '0;
      dataCount <= '0;
    end else begin
      state <= nextState;
      if (state == idle) begin
        addrCount <= '0;
        dataCount <= '0;
        // Enable and victim are fixed for the whole miss
        if (fetchValid && !hit) begin
          bypass <= !cacheEnable;
          victim <= victimNext;
        end
      end else begin
        if ((state == fill) && busReady) begin
          addrCount <= addrCount + 1'b1;
        end
        if (dataBeat) begin
          dataCount <= dataCount + 1'b1;
        end
      end
    end
  end

  // LRU bit names the way to replace next
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if ((state == idle) && fetchValid && hit) begin
      lruBits[reqIndex] <= hit0;
    end else if (lastData) begin
      lruBits[reqIndex] <= !victim;
    end
  end

  // Word from an uncached read, returned in settle
  always_ff @(posedge clk) begin
    if (bypass && (state == lastBeat) && busReady) begin
      uncachedWord <= busRdata;
    end
  end

endmodule

`default_nettype wire

// ==== hw/icacheTop.sv ====
// **********************************************************************
// Instruction cache top: controller and four way arrays
// **********************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "icache_settings.svh"

module icacheTop
  import icachePkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     cacheEnable,
  input  logic     fetchValid,
  input  fetchReqT fetchReq,
  output logic     fetchReady,
  output wordT     fetchInstr,
  output busReqT   busReq,
  input  logic     busReady,
  input  wordT     busRdata
);

  localparam int indexW    = $clog2(`ICACHE_SETS);
  localparam int offsetW   = $clog2(`ICACHE_LINE_WORDS);
  localparam int dataDepth = `ICACHE_SETS * `ICACHE_LINE_WORDS;

  tagEntryT                  tagRead0;
  tagEntryT                  tagRead1;
  tagEntryT                  tagWriteEntry;
  wordT                      dataRead0;
  wordT                      dataRead1;
  logic                      tagWrite0;
  logic                      tagWrite1;
  logic                      dataWrite0;
  logic                      dataWrite1;
  logic [indexW-1:0]         setIndex;
  logic [indexW+offsetW-1:0] dataReadIndex;
  logic [indexW+offsetW-1:0] dataWriteIndex;

  // Arrays are indexed straight from the held fetch address
  assign setIndex      = fetchReq.addr[offsetW+2 +: indexW];
  assign dataReadIndex = fetchReq.addr[2 +: indexW+offsetW];

  icacheController icacheController_inst (
    .clk, .reset, .cacheEnable, .fetchValid, .fetchReq, .fetchReady, .fetchInstr,
    .tagRead0, .tagRead1, .dataRead0, .dataRead1,
    .tagWrite0, .tagWrite1, .tagWriteEntry,
    .dataWrite0, .dataWrite1, .dataWriteIndex,
    .busReq, .busReady, .busRdata
  );

  icacheWayArray #(.entryT(tagEntryT), .depth(`ICACHE_SETS)) tagWay0 (
    .clk, .reset, .writeEnable(tagWrite0), .writeIndex(setIndex),
    .writeEntry(tagWriteEntry), .readIndex(setIndex), .readEntry(tagRead0)
  );

  icacheWayArray #(.entryT(tagEntryT), .depth(`ICACHE_SETS)) tagWay1 (
    .clk, .reset, .writeEnable(tagWrite1), .writeIndex(setIndex),
    .writeEntry(tagWriteEntry), .readIndex(setIndex), .readEntry(tagRead1)
  );

  // Data arrays take refill words straight off the bus
  icacheWayArray #(.entryT(wordT), .depth(dataDepth)) dataWay0 (
    .clk, .reset, .writeEnable(dataWrite0), .writeIndex(dataWriteIndex),
    .writeEntry(busRdata), .readIndex(dataReadIndex), .readEntry(dataRead0)
  );

  icacheWayArray #(.entryT(wordT), .depth(dataDepth)) dataWay1 (
    .clk, .reset, .writeEnable(dataWrite1), .writeIndex(dataWriteIndex),
    .writeEntry(busRdata), .readIndex(dataReadIndex), .readEntry(dataRead1)
  );

endmodule

`default_nettype wire

// ==== tests/icacheClockGen.sv ====
// **********************************************************************
// Testbench clock, 20 ns period, and a three cycle reset
// **********************************************************************
`timescale 1ns/1ps
`default_nettype none

module icacheClockGen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== tests/icacheChecker.sv ====
// **********************************************************************
// Watches the fetch and bus ports, counts bus beats per fetch and
// compares each completed fetch against its vector
// **********************************************************************
`timescale 1ns/1ps
`default_nettype none

module icacheChecker
  import icachePkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     fetchValid,
  input  fetchReqT fetchReq,
  input  logic     fetchReady,
  input  wordT     fetchInstr,
  input  busReqT   busReq,
  input  logic     busReady,
  input  int       testNum,
  input  wordT     expInstr,
  input  int       expBeats,
  output int       passCount,
  output int       failCount
);

  int beatCount = 0;
  int passTotal = 0;
  int failTotal = 0;

  assign passCount = passTotal;
  assign failCount = failTotal;

  always @(posedge clk) begin : compare
    logic mismatch;
    mismatch = 1'b0;
    if (reset) begin
      beatCount = 0;
    end else if (fetchValid && fetchReady) begin
      // Handshake cycle, the instruction is valid only now
      if (fetchInstr != expInstr) begin
        $display("FAILED %0d ns: fetchInstr expected %h actual %h",
                 $time, expInstr, fetchInstr);
        mismatch = 1'b1;
      end
      if (beatCount != expBeats) begin
        $display("FAILED %0d ns: busBeats expected %0d actual %0d",
                 $time, expBeats, beatCount);
        mismatch = 1'b1;
      end
      if (mismatch) begin
        failTotal++;
        $display("test %0d at %h: mismatch", testNum, fetchReq.addr);
      end else begin
        passTotal++;
        $display("test %0d at %h: ok, instr %h, %0d bus beats",
                 testNum, fetchReq.addr, fetchInstr, beatCount);
      end
      beatCount = 0;
    end else if (busReq.valid && busReady) begin
      // Accepted address phase
      beatCount++;
    end
  end

endmodule

`default_nettype wire

// ==== tests/icacheTb.sv ====
// **********************************************************************
// Instruction cache testbench top: vector driven fetches, bus memory
// model with random wait states, timeout and final report
// **********************************************************************
`timescale 1ns/1ps
`default_nettype none

module icacheTb
  import icachePkg::*;
;

  localparam int maxVectors = 64;

  logic        clk;
  logic        reset;
  logic        cacheEnable;
  logic        fetchValid;
  fetchReqT    fetchReq;
  logic        fetchReady;
  wordT        fetchInstr;
  busReqT      busReq;
  logic        busReady;
  wordT        busRdata;
  int          testNum;
  wordT        expInstr;
  int          expBeats;
  int          passCount;
  int          failCount;
  logic [31:0] vecMem [maxVectors*4];
  int          numVectors = 0;
  int          cycleLimit = 0;
  int          cycleCount = 0;

  // Bus memory holds the word address with its upper half inverted
  function automatic wordT memoryWord(input logic [31:0] addr);
    return {~addr[31:16], addr[15:0]};
  endfunction

  function automatic logic [31:0] xorshiftNext(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  icacheClockGen clockGen_inst (.clk, .reset);

  icacheTop icacheTop_inst (
    .clk, .reset, .cacheEnable, .fetchValid, .fetchReq, .fetchReady, .fetchInstr,
    .busReq, .busReady, .busRdata
  );

  icacheChecker icacheChecker_inst (
    .clk, .reset, .fetchValid, .fetchReq, .fetchReady, .fetchInstr,
    .busReq, .busReady, .testNum, .expInstr, .expBeats, .passCount, .failCount
  );

  // Pipelined bus, data follows its address on the next ready cycle
  initial begin : busModel
    logic [31:0] rng;
    logic [1:0]  waitLeft;
    rng = 32'd65;
    waitLeft = 2'd0;
    busReady <= 1'b0;
    busRdata <= '0;
    forever begin
      @(posedge clk);
      if (reset) begin
        busReady <= 1'b0;
        busRdata <= '0;
      end else begin
        if (busReq.valid && busReady) begin
          busRdata <= memoryWord(busReq.addr);
        end
        if (waitLeft != 2'd0) begin
          busReady <= 1'b0;
          waitLeft = waitLeft - 2'd1;
        end else begin
          // Zero to three wait states before the next ready cycle
          busReady <= 1'b1;
          rng = xorshiftNext(rng);
          waitLeft = rng[1:0];
        end
      end
    end
  end

  initial begin : stimulus
    fetchValid <= 1'b0;
    fetchReq <= '0;
    cacheEnable <= 1'b0;
    testNum <= 0;
    expInstr <= '0;
    expBeats <= 0;
    // Enable column above 1 marks the end of the file
    for (int i = 0; i < maxVectors*4; i++) begin
      vecMem[i] = '1;
    end
    $readmemh("tests/icache_vectors.txt", vecMem);
    while (numVectors < maxVectors && vecMem[4*numVectors+1] <= 32'd1) begin
      numVectors++;
    end
    cycleLimit = numVectors * 40;
    @(negedge reset);
    @(posedge clk);
    for (int v = 0; v < numVectors; v++) begin
      fetchValid <= 1'b1;
      fetchReq <= '{addr: vecMem[4*v]};
      cacheEnable <= vecMem[4*v+1][0];
      expInstr <= vecMem[4*v+2];
      expBeats <= int'(vecMem[4*v+3]);
      testNum <= v + 1;
      // Hold the request until the handshake
      @(posedge clk);
      while (!(fetchValid && fetchReady)) begin
        @(posedge clk);
      end
    end
    fetchValid <= 1'b0;
    repeat (2) @(posedge clk);
    if (numVectors == 0) begin
      $display("no vectors were read from tests/icache_vectors.txt");
    end
    $display("summary: %0d of %0d vectors matched, %0d mismatched",
             passCount, numVectors, failCount);
    if (numVectors > 0 && failCount == 0 && passCount == numVectors) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Four beats with three wait states each, plus overhead
  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("timeout: the fetches did not complete within %0d cycles", cycleLimit);
      $display("tests failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hw
hw/icachePkg.sv
hw/icacheWayArray.sv
hw/icacheController.sv
hw/icacheTop.sv
tests/icacheClockGen.sv
tests/icacheChecker.sv
tests/icacheTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the instruction cache testbench with Verilator, run it, then check the log
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module icacheTb -f list.f \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/VicacheTb | tee sim.log
grep -qx "all tests passed" sim.log \
  && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }

// ==== tests/icache_vectors.txt ====
// Columns: fetch byte address, cache enable, expected instruction,
// expected number of accepted bus address phases
00010034 1 FFFE0034 4 // cold miss in set 3
00010030 1 FFFE0030 0
0001003C 1 FFFE003C 0
00010038 1 FFFE0038 0
00020030 1 FFFD0030 4 // second line fills way 1
00020038 1 FFFD0038 0
00010034 1 FFFE0034 0
00030030 1 FFFC0030 4 // third line evicts the older one
0001003C 1 FFFE003C 0
00020034 1 FFFD0034 4
0002003C 1 FFFD003C 0
0001003C 0 FFFE003C 1 // uncached reads
00050040 0 FFFA0040 1
00020030 0 FFFD0030 1
00010030 1 FFFE0030 0 // enabled again
00020038 1 FFFD0038 0
12340100 1 EDCB0100 4
12340108 1 EDCB0108 0
ABCD00F4 1 543200F4 4
ABCD00F0 1 543200F0 0
00030034 1 FFFC0034 4
00020034 1 FFFD0034 0
